//--- rtl/noc_proto_pkg.sv
`default_nettype none

package noc_proto_pkg;

    localparam int FLIT_SIZE   = 32;
    localparam int HEADER_SIZE = 13;
    localparam int HDR_IDX_W   = $clog2(HEADER_SIZE + 1);

    typedef logic [FLIT_SIZE-1:0] flit_t;

    localparam flit_t MAPPER_ADDRESS   = 32'h0000_0000;
    localparam flit_t INJECTOR_ADDRESS = 32'h8000_0100; // Peripheral port of router 1x0

    typedef enum logic [FLIT_SIZE-1:0] {
        MESSAGE_DELIVERY = 32'h0000_0001,
        MESSAGE_REQUEST  = 32'h0000_0002,
        DATA_AV          = 32'h0000_0031,
        TASK_ALLOCATION  = 32'h0000_0040
    } service_e;

    // First payload word of a delivery
    typedef enum logic [FLIT_SIZE-1:0] {
        NEW_APP                = 32'h0000_0150,
        APP_ALLOCATION_REQUEST = 32'h0000_0240,
        APP_MAPPING_COMPLETE   = 32'h0000_0241
    } msg_e;

endpackage

`default_nettype wire

//--- rtl/injector_pkg.sv
`default_nettype none

package injector_pkg;

    localparam int MAX_PAYLOAD_SIZE = 32;
    localparam int MAX_TASKS        = 30;  // Message word and app id take two payload slots
    localparam int AUX_SIZE         = 2;
    localparam int PAY_IDX_W        = $clog2(MAX_PAYLOAD_SIZE);
    localparam int AUX_IDX_W        = $clog2(AUX_SIZE + 1);

    typedef logic [8:0] task_cnt_t;
    typedef logic [7:0] task_idx_t;

    typedef enum logic [3:0] {
        INJ_IDLE, INJ_SEND_DESCRIPTOR, INJ_WAIT_ALLOC,
        INJ_RX_TEXT, INJ_RX_DATA, INJ_RX_BSS, INJ_RX_ENTRY,
        INJ_SEND_TASK, INJ_NEXT_TASK, INJ_WAIT_COMPLETE
    } inject_state_e;

    typedef enum logic [2:0] {
        SND_IDLE, SND_DATA_AV, SND_WAIT_REQUEST, SND_PACKET, SND_FINISHED
    } send_state_e;

    typedef enum logic [3:0] {
        RCV_IDLE, RCV_HEADER, RCV_SIZE, RCV_PACKET, RCV_SERVICE,
        RCV_DELIVERY, RCV_DROP, RCV_WAIT_DLVR, RCV_WAIT_ALLOC, RCV_MAP_COMPLETE
    } recv_state_e;

    typedef enum logic {PKT_DESCRIPTOR, PKT_TASK} pkt_kind_e;

    typedef enum logic [1:0] {FIELD_TEXT, FIELD_DATA, FIELD_BSS, FIELD_ENTRY} size_field_e;

endpackage

`default_nettype wire

//--- rtl/inject_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module inject_ctrl (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      src_rx_i,
    input  noc_proto_pkg::flit_t      src_data_i,
    output logic                      src_credit_o,
    input  logic                      stream_credit_i,
    output logic                      send_start_o,
    output injector_pkg::pkt_kind_e   send_kind_o,
    input  logic                      send_done_i,
    output logic                      size_load_o,
    output injector_pkg::size_field_e size_field_o,
    output injector_pkg::task_idx_t   task_idx_o,
    output noc_proto_pkg::flit_t      task_target_o,
    output noc_proto_pkg::flit_t      app_id_o,
    output injector_pkg::task_cnt_t   task_cnt_o,
    input  logic                      alloc_i,
    input  noc_proto_pkg::flit_t      app_id_i,
    input  noc_proto_pkg::flit_t      task_addr_i,
    output logic                      alloc_release_o,
    input  logic                      map_done_i
);

    import injector_pkg::*;

    inject_state_e state_q;
    inject_state_e state_d;
    logic          size_state;
    logic          last_task;

    assign size_state = state_q inside {INJ_RX_TEXT, INJ_RX_DATA, INJ_RX_BSS, INJ_RX_ENTRY};
    assign last_task  = task_cnt_t'(task_idx_o) == task_cnt_o - 1'b1;

    always_comb begin
        case (state_q)
            INJ_IDLE:            state_d = src_rx_i ? INJ_SEND_DESCRIPTOR : INJ_IDLE;
            INJ_SEND_DESCRIPTOR: state_d = send_done_i ? INJ_WAIT_ALLOC : state_q;
            INJ_WAIT_ALLOC:      state_d = alloc_i ? INJ_RX_TEXT : state_q;
            INJ_RX_TEXT:         state_d = src_rx_i ? INJ_RX_DATA : state_q;
            INJ_RX_DATA:         state_d = src_rx_i ? INJ_RX_BSS : state_q;
            INJ_RX_BSS:          state_d = src_rx_i ? INJ_RX_ENTRY : state_q;
            INJ_RX_ENTRY:        state_d = src_rx_i ? INJ_SEND_TASK : state_q;
            INJ_SEND_TASK:       state_d = send_done_i ? INJ_NEXT_TASK : state_q;
            INJ_NEXT_TASK:       state_d = last_task ? INJ_WAIT_COMPLETE : INJ_RX_TEXT;
            default:             state_d = map_done_i ? INJ_IDLE : state_q;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q      <= INJ_IDLE;
            send_start_o <= 1'b0;
            task_cnt_o   <= '0;
            task_idx_o   <= '0;
        end else begin
            state_q      <= state_d;
            send_start_o <= (state_q inside {INJ_IDLE, INJ_RX_ENTRY}) && src_rx_i;
            if (state_q == INJ_IDLE && src_rx_i) begin
                task_cnt_o <= task_cnt_t'(src_data_i); // Count word is left for the descriptor
            end
            if (state_q == INJ_WAIT_ALLOC) begin
                task_idx_o <= '0;
            end else if (state_q == INJ_NEXT_TASK && !last_task) begin
                task_idx_o <= task_idx_o + 1'b1;
            end
        end
    end

    always_comb begin
        case (state_q)
            INJ_RX_DATA:  size_field_o = FIELD_DATA;
            INJ_RX_BSS:   size_field_o = FIELD_BSS;
            INJ_RX_ENTRY: size_field_o = FIELD_ENTRY;
            default:      size_field_o = FIELD_TEXT;
        endcase
    end

    // Size words are taken here, code and descriptor words by the sender
    assign src_credit_o    = size_state || stream_credit_i;
    assign size_load_o     = size_state && src_rx_i;
    assign send_kind_o     = (state_q == INJ_SEND_TASK) ? PKT_TASK : PKT_DESCRIPTOR;
    assign alloc_release_o = (state_q == INJ_NEXT_TASK) && last_task;
    assign task_target_o   = task_addr_i;
    assign app_id_o        = app_id_i;

endmodule

`default_nettype wire

//--- rtl/packet_sender.sv
`timescale 1ns/1ps
`default_nettype none

module packet_sender (
    input  logic                      clk_i,
    input  logic                      rst_ni,
    input  logic                      send_start_i,
    input  injector_pkg::pkt_kind_e   send_kind_i,
    output logic                      send_done_o,
    input  logic                      size_load_i,
    input  injector_pkg::size_field_e size_field_i,
    input  injector_pkg::task_idx_t   task_idx_i,
    input  noc_proto_pkg::flit_t      task_target_i,
    input  noc_proto_pkg::flit_t      app_id_i,
    input  injector_pkg::task_cnt_t   task_cnt_i,
    input  logic                      request_i,
    input  noc_proto_pkg::flit_t      req_addr_i,
    input  noc_proto_pkg::flit_t      req_prod_i,
    input  noc_proto_pkg::flit_t      req_cons_i,
    input  logic                      src_rx_i,
    input  noc_proto_pkg::flit_t      src_data_i,
    output logic                      stream_credit_o,
    output logic                      noc_tx_o,
    output noc_proto_pkg::flit_t      noc_data_o,
    input  logic                      noc_credit_i
);

    import noc_proto_pkg::*;
    import injector_pkg::*;

    send_state_e          state_q;
    send_state_e          state_d;
    flit_t                hdr [HEADER_SIZE];
    logic [HDR_IDX_W-1:0] hdr_idx;
    logic [AUX_IDX_W-1:0] aux_idx;
    logic [AUX_IDX_W-1:0] aux_len;
    flit_t                sent_cnt;
    flit_t                aux_flit;
    logic                 start_desc;
    logic                 start_dlvr;
    logic                 in_stream;
    logic                 flit_moved;
    logic                 last_flit;

    assign start_desc = (state_q == SND_IDLE) && send_start_i && (send_kind_i == PKT_DESCRIPTOR);
    assign start_dlvr = (state_q == SND_WAIT_REQUEST) && request_i;
    assign in_stream  = (hdr_idx == HEADER_SIZE) && (aux_idx == aux_len);
    assign flit_moved = noc_tx_o && noc_credit_i;
    assign last_flit  = flit_moved && (sent_cnt == hdr[1] + 1'b1); // P+2 flits in all
    assign aux_flit   = (aux_idx == '0) ? flit_t'(NEW_APP) : INJECTOR_ADDRESS;

    always_ff @(posedge clk_i) begin
        if (start_desc || start_dlvr || (size_load_i && size_field_i == FIELD_TEXT)) begin
            for (int i = 0; i < HEADER_SIZE; i++) begin
                hdr[i] <= '0;
            end
        end
        if (start_desc) begin
            hdr[0] <= MAPPER_ADDRESS;
            hdr[1] <= flit_t'(HEADER_SIZE - 2);
            hdr[2] <= DATA_AV;
            hdr[3] <= INJECTOR_ADDRESS;
            hdr[8] <= INJECTOR_ADDRESS;
        end else if (start_dlvr) begin
            hdr[0] <= req_addr_i;
            hdr[1] <= flit_t'({task_cnt_i, 1'b0}) + flit_t'(HEADER_SIZE + 1);
            hdr[2] <= MESSAGE_DELIVERY;
            hdr[3] <= req_prod_i;
            hdr[4] <= req_cons_i;
            hdr[8] <= (flit_t'({task_cnt_i, 1'b0}) + flit_t'(AUX_SIZE + 1)) << 2; // Bytes
        end else if (size_load_i) begin
            case (size_field_i)
                FIELD_TEXT: begin
                    hdr[0]  <= task_target_i;
                    hdr[1]  <= src_data_i;
                    hdr[2]  <= TASK_ALLOCATION;
                    hdr[3]  <= flit_t'({app_id_i[7:0], task_idx_i});
                    hdr[4]  <= MAPPER_ADDRESS;
                    hdr[10] <= src_data_i;
                end
                FIELD_DATA: begin
                    hdr[1] <= hdr[1] + src_data_i;
                    hdr[9] <= src_data_i;
                end
                FIELD_BSS: begin
                    hdr[1]  <= hdr[1] >> 2;           // Bytes to code words
                    hdr[11] <= src_data_i;
                end
                default: begin
                    hdr[1]  <= hdr[1] + flit_t'(HEADER_SIZE - 2);
                    hdr[12] <= src_data_i;
                end
            endcase
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q  <= SND_IDLE;
            hdr_idx  <= '0;
            aux_idx  <= '0;
            aux_len  <= '0;
            sent_cnt <= '0;
        end else begin
            state_q <= state_d;
            if (state_q inside {SND_IDLE, SND_WAIT_REQUEST}) begin
                hdr_idx  <= '0;
                aux_idx  <= '0;
                sent_cnt <= '0;
            end else if (flit_moved) begin
                sent_cnt <= sent_cnt + 1'b1;
                if (hdr_idx != HEADER_SIZE) begin
                    hdr_idx <= hdr_idx + 1'b1;
                end else if (aux_idx != aux_len) begin
                    aux_idx <= aux_idx + 1'b1;
                end
            end
            if (start_dlvr) begin
                aux_len <= AUX_IDX_W'(AUX_SIZE);
            end else if (state_q == SND_IDLE) begin
                aux_len <= '0;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            SND_IDLE: begin
                if (send_start_i) begin
                    state_d = (send_kind_i == PKT_TASK) ? SND_PACKET : SND_DATA_AV;
                end
            end
            SND_DATA_AV:      state_d = last_flit ? SND_WAIT_REQUEST : state_q;
            SND_WAIT_REQUEST: state_d = request_i ? SND_PACKET : state_q;
            SND_PACKET:       state_d = last_flit ? SND_FINISHED : state_q;
            default:          state_d = SND_IDLE;
        endcase
    end

    always_comb begin
        case (state_q)
            SND_DATA_AV: noc_tx_o = 1'b1;
            SND_PACKET:  noc_tx_o = in_stream ? src_rx_i : 1'b1;
            default:     noc_tx_o = 1'b0;
        endcase
    end

    assign stream_credit_o = (state_q == SND_PACKET) && in_stream && noc_credit_i;
    assign send_done_o     = (state_q == SND_FINISHED);
    assign noc_data_o      = (hdr_idx != HEADER_SIZE) ? hdr[hdr_idx]
                           : (aux_idx != aux_len)     ? aux_flit
                           : src_data_i;

endmodule

`default_nettype wire

//--- rtl/packet_receiver.sv
`timescale 1ns/1ps
`default_nettype none

module packet_receiver (
    input  logic                    clk_i,
    input  logic                    rst_ni,
    input  logic                    noc_rx_i,
    input  noc_proto_pkg::flit_t    noc_data_i,
    output logic                    noc_credit_o,
    input  logic                    send_done_i,
    input  logic                    alloc_release_i,
    input  injector_pkg::task_idx_t task_idx_i,
    output logic                    request_o,
    output noc_proto_pkg::flit_t    req_addr_o,
    output noc_proto_pkg::flit_t    req_prod_o,
    output noc_proto_pkg::flit_t    req_cons_o,
    output logic                    alloc_o,
    output noc_proto_pkg::flit_t    app_id_o,
    output noc_proto_pkg::flit_t    task_addr_o,
    output logic                    map_done_o
);

    import noc_proto_pkg::*;
    import injector_pkg::*;

    recv_state_e          state_q;
    recv_state_e          state_d;
    flit_t                in_hdr [HEADER_SIZE];
    flit_t                in_pay [MAX_PAYLOAD_SIZE];
    flit_t                rx_cnt;                     // Flits taken of the current packet
    logic                 accept;
    logic                 last_flit;
    logic                 oversize;
    logic [PAY_IDX_W-1:0] pay_idx;
    logic [PAY_IDX_W-1:0] task_slot;

    assign noc_credit_o = state_q inside {RCV_IDLE, RCV_HEADER, RCV_SIZE, RCV_PACKET, RCV_DROP};
    assign accept    = noc_rx_i && noc_credit_o;
    assign last_flit = accept && (rx_cnt == in_hdr[1] + 1'b1);
    assign oversize  = in_hdr[1] > flit_t'(MAX_PAYLOAD_SIZE + HEADER_SIZE - 2);
    assign pay_idx   = PAY_IDX_W'(rx_cnt - HEADER_SIZE);
    assign task_slot = PAY_IDX_W'(task_idx_i + 2'd2);

    always_ff @(posedge clk_i) begin
        if (accept && rx_cnt < HEADER_SIZE) begin
            in_hdr[rx_cnt[HDR_IDX_W-1:0]] <= noc_data_i;
        end else if (accept && state_q == RCV_PACKET) begin
            in_pay[pay_idx] <= noc_data_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= RCV_IDLE;
            rx_cnt  <= '0;
        end else begin
            state_q <= state_d;
            if (state_d == RCV_IDLE) begin
                rx_cnt <= '0;
            end else if (accept) begin
                rx_cnt <= rx_cnt + 1'b1;
            end
        end
    end

    always_comb begin
        state_d = state_q;
        case (state_q)
            RCV_IDLE, RCV_HEADER: state_d = noc_rx_i ? RCV_SIZE : RCV_HEADER;
            RCV_SIZE:             state_d = noc_rx_i ? RCV_PACKET : RCV_SIZE;
            RCV_PACKET: begin
                if (oversize) begin
                    state_d = RCV_DROP;
                end else if (last_flit) begin
                    state_d = RCV_SERVICE;
                end
            end
            RCV_SERVICE: begin
                case (in_hdr[2])
                    MESSAGE_REQUEST:  state_d = RCV_WAIT_DLVR;
                    MESSAGE_DELIVERY: state_d = RCV_DELIVERY;
                    default:          state_d = RCV_IDLE;
                endcase
            end
            RCV_DELIVERY: begin
                case (in_pay[0])
                    APP_ALLOCATION_REQUEST: state_d = RCV_WAIT_ALLOC;
                    APP_MAPPING_COMPLETE:   state_d = RCV_MAP_COMPLETE;
                    default:                state_d = RCV_IDLE;
                endcase
            end
            RCV_DROP:       state_d = last_flit ? RCV_IDLE : RCV_DROP;
            RCV_WAIT_DLVR:  state_d = send_done_i ? RCV_IDLE : RCV_WAIT_DLVR;
            RCV_WAIT_ALLOC: state_d = alloc_release_i ? RCV_IDLE : RCV_WAIT_ALLOC;
            default:        state_d = RCV_IDLE;
        endcase
    end

    // Header stays put while credit is low, so the requester fields hold
    assign request_o   = (state_q == RCV_SERVICE) && (in_hdr[2] == MESSAGE_REQUEST);
    assign req_addr_o  = in_hdr[8];
    assign req_prod_o  = in_hdr[3];
    assign req_cons_o  = in_hdr[4];
    assign alloc_o     = (state_q == RCV_WAIT_ALLOC);
    assign app_id_o    = in_pay[1];
    assign task_addr_o = in_pay[task_slot];
    assign map_done_o  = (state_q == RCV_MAP_COMPLETE);

endmodule

`default_nettype wire

//--- rtl/task_injector.sv
`timescale 1ns/1ps
`default_nettype none

module task_injector (
    input  logic                 clk_i,
    input  logic                 rst_ni,
    input  logic                 src_rx_i,
    input  noc_proto_pkg::flit_t src_data_i,
    output logic                 src_credit_o,
    output logic                 noc_tx_o,
    output noc_proto_pkg::flit_t noc_data_o,
    input  logic                 noc_credit_i,
    input  logic                 noc_rx_i,
    input  noc_proto_pkg::flit_t noc_data_i,
    output logic                 noc_credit_o
);

    import noc_proto_pkg::*;
    import injector_pkg::*;

    logic        send_start;
    pkt_kind_e   send_kind;
    logic        send_done;
    logic        stream_credit;
    logic        size_load;
    size_field_e size_field;
    task_idx_t   task_idx;
    task_cnt_t   task_cnt;
    flit_t       task_target;
    flit_t       task_app_id;    // App id as seen by the sender
    logic        alloc;
    logic        alloc_release;
    flit_t       alloc_app_id;
    flit_t       task_addr;
    logic        map_done;
    logic        request;
    flit_t       req_addr;
    flit_t       req_prod;
    flit_t       req_cons;

    inject_ctrl u_ctrl (
        .clk_i, .rst_ni, .src_rx_i, .src_data_i, .src_credit_o,
        .stream_credit_i(stream_credit), .send_start_o(send_start), .send_kind_o(send_kind),
        .send_done_i(send_done), .size_load_o(size_load), .size_field_o(size_field),
        .task_idx_o(task_idx), .task_target_o(task_target), .app_id_o(task_app_id),
        .task_cnt_o(task_cnt), .alloc_i(alloc), .app_id_i(alloc_app_id),
        .task_addr_i(task_addr), .alloc_release_o(alloc_release), .map_done_i(map_done)
    );

    packet_sender u_sender (
        .clk_i, .rst_ni, .send_start_i(send_start), .send_kind_i(send_kind),
        .send_done_o(send_done), .size_load_i(size_load), .size_field_i(size_field),
        .task_idx_i(task_idx), .task_target_i(task_target), .app_id_i(task_app_id),
        .task_cnt_i(task_cnt), .request_i(request), .req_addr_i(req_addr),
        .req_prod_i(req_prod), .req_cons_i(req_cons), .src_rx_i, .src_data_i,
        .stream_credit_o(stream_credit), .noc_tx_o, .noc_data_o, .noc_credit_i
    );

    packet_receiver u_receiver (
        .clk_i, .rst_ni, .noc_rx_i, .noc_data_i, .noc_credit_o,
        .send_done_i(send_done), .alloc_release_i(alloc_release), .task_idx_i(task_idx),
        .request_o(request), .req_addr_o(req_addr), .req_prod_o(req_prod),
        .req_cons_o(req_cons), .alloc_o(alloc), .app_id_o(alloc_app_id),
        .task_addr_o(task_addr), .map_done_o(map_done)
    );

endmodule

`default_nettype wire

//--- tb/task_injector_checker.sv
`timescale 1ns/1ps
`default_nettype none

module task_injector_checker (
    input logic                 clk_i,
    input logic                 rst_ni,
    input logic                 noc_tx_o,
    input noc_proto_pkg::flit_t noc_data_o,
    input logic                 noc_credit_i,
    input logic                 src_credit_o
);

    // Flit stays on the port until the router takes it
    hold_flit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        noc_tx_o && !noc_credit_i |=> noc_tx_o && $stable(noc_data_o))
        else $error("Output flit changed under back-pressure");

    // Pass-through words are only taken when the router takes them too
    stream_credit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        src_credit_o && noc_tx_o |-> noc_credit_i)
        else $error("Source word taken while the NoC port is stalled");

    known_flit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        noc_tx_o |-> !$isunknown(noc_data_o))
        else $error("Unknown value on a valid output flit");

endmodule

bind task_injector task_injector_checker u_checker (
    .clk_i, .rst_ni, .noc_tx_o, .noc_data_o, .noc_credit_i, .src_credit_o
);

`default_nettype wire

//--- tb/tb_mapper_model.svh
// One clock cycle as seen by the mapper and the host source
task automatic step_cycle(output logic took, output flit_t f);
    @(negedge clk_i);
    noc_credit_i = (rand_bits(2) != 32'h0);  // About one gap in four
    src_rx_i     = (src_q.size() != 0);
    src_data_i   = src_rx_i ? src_q[0] : '0;
    noc_rx_i     = (in_q.size() != 0);
    noc_data_i   = noc_rx_i ? in_q[0] : '0;
    #1;
    took = noc_tx_o && noc_credit_i;
    f    = noc_data_o;
    if (src_rx_i && src_credit_o) begin
        void'(src_q.pop_front());
    end
    if (noc_rx_i && noc_credit_o) begin
        void'(in_q.pop_front());
    end
    if (drain_mode) begin
        check_bit("noc_credit_o", noc_credit_o, 1'b1);
    end
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > cycle_limit) begin
        abort_run("Timeout: the injector stopped making progress");
    end
endtask

task automatic get_flit(output flit_t f);
    logic took;
    took = 1'b0;
    while (!took) begin
        step_cycle(took, f);
    end
endtask

task automatic receive_packet(input flit_t exp_q[$]);
    flit_t f;
    for (int n = 0; n < exp_q.size(); n++) begin
        get_flit(f);
        if (n == 2) begin
            check_service(service_e'(f), service_e'(exp_q[n]));
        end else begin
            check_flit($sformatf("noc_data_o flit %0d", n), f, exp_q[n]);
        end
    end
endtask

// Mapper to injector packet with P counted from the payload
task automatic queue_packet(input flit_t svc, input flit_t f3, input flit_t f4,
                            input flit_t f8, input flit_t pay[$]);
    flit_t hdr [HEADER_SIZE];
    for (int i = 0; i < HEADER_SIZE; i++) begin
        hdr[i] = '0;
    end
    hdr[0] = INJECTOR_ADDRESS;
    hdr[1] = flit_t'(pay.size() + HEADER_SIZE - 2);
    hdr[2] = svc;
    hdr[3] = f3;
    hdr[4] = f4;
    hdr[8] = f8;
    for (int i = 0; i < HEADER_SIZE; i++) begin
        in_q.push_back(hdr[i]);
    end
    foreach (pay[i]) begin
        in_q.push_back(pay[i]);
    end
endtask

// Sends what is queued while the injector must stay silent
task automatic flush_input(input int extra);
    logic  took;
    flit_t f;
    int    left;
    left = extra;
    while (in_q.size() != 0 || left > 0) begin
        if (in_q.size() == 0) begin
            left = left - 1;
        end
        step_cycle(took, f);
        check_bit("noc_tx_o", noc_tx_o, 1'b0);
        check_bit("src_credit_o", src_credit_o, 1'b0);
    end
endtask

//--- tb/tb_task_injector.sv
`timescale 1ns/1ps
`default_nettype none

module tb_task_injector;

    import noc_proto_pkg::*;
    import injector_pkg::*;

    localparam int NUM_APPS = 2;

    logic  clk_i;
    logic  rst_ni;
    logic  src_rx_i;
    flit_t src_data_i;
    logic  src_credit_o;
    logic  noc_tx_o;
    flit_t noc_data_o;
    logic  noc_credit_i;
    logic  noc_rx_i;
    flit_t noc_data_i;
    logic  noc_credit_o;

    logic [31:0] lfsr;
    int          cycle_cnt;
    int          cycle_limit;
    logic        drain_mode;
    flit_t       src_q [$];
    flit_t       in_q [$];
    int          app_tasks [NUM_APPS];
    flit_t       app_id [NUM_APPS];
    flit_t       req_addr [NUM_APPS];
    flit_t       req_prod [NUM_APPS];
    flit_t       req_cons [NUM_APPS];
    flit_t       text_sz [NUM_APPS][MAX_TASKS];
    flit_t       data_sz [NUM_APPS][MAX_TASKS];
    flit_t       bss_sz [NUM_APPS][MAX_TASKS];
    flit_t       entry_sz [NUM_APPS][MAX_TASKS];
    flit_t       target [NUM_APPS][MAX_TASKS];

    task_injector UUT (.*);

    always #50 clk_i = ~clk_i;

    // Galois LFSR stepped once per bit
    function automatic flit_t rand_bits(input int n);
        flit_t v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[FLIT_SIZE-2:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'hB4BC_D35C) : (lfsr >> 1);
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_flit(input string name, input flit_t got, input flit_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
            abort_run("A flit sent by the injector is wrong");
        end
    endtask

    task automatic check_service(input service_e got, input service_e exp);
        if (got !== exp) begin
            $display("Error at %0t: noc_data_o service flit is %h, expected %h",
                     $time, got, exp);
            abort_run("The injector sent the wrong service");
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
            abort_run("A control signal has the wrong level");
        end
    endtask

    // Header of DATA_AV (dlvr low) or of the descriptor delivery
    function automatic flit_t ref_desc_flit(input int a, input int n, input logic dlvr);
        case (n)
            0:       return dlvr ? req_addr[a] : MAPPER_ADDRESS;
            1:       return dlvr ? flit_t'(2 * app_tasks[a] + 14) : flit_t'(11);
            2:       return dlvr ? flit_t'(MESSAGE_DELIVERY) : flit_t'(DATA_AV);
            3:       return dlvr ? req_prod[a] : INJECTOR_ADDRESS;
            4:       return dlvr ? req_cons[a] : '0;
            8:       return dlvr ? flit_t'((2 * app_tasks[a] + 3) * 4) : INJECTOR_ADDRESS;
            default: return '0;
        endcase
    endfunction

    function automatic flit_t ref_task_flit(input int a, input int t, input int n);
        case (n)
            0:       return target[a][t];
            1:       return ((text_sz[a][t] + data_sz[a][t]) >> 2) + 32'd11;
            2:       return TASK_ALLOCATION;
            3:       return {16'h0, app_id[a][7:0], t[7:0]};
            4:       return MAPPER_ADDRESS;
            9:       return data_sz[a][t];
            10:      return text_sz[a][t];
            11:      return bss_sz[a][t];
            12:      return entry_sz[a][t];
            default: return '0;
        endcase
    endfunction

    `include "tb_mapper_model.svh"

    task automatic run_app(input int a);
        flit_t desc_q [$];
        flit_t exp_q [$];
        flit_t pay [$];
        int    code;
        desc_q.push_back(flit_t'(app_tasks[a]));  // Count word opens the descriptor
        for (int i = 0; i < 2 * app_tasks[a]; i++) begin
            desc_q.push_back(rand_bits(32));
        end
        foreach (desc_q[i]) begin
            src_q.push_back(desc_q[i]);
        end
        for (int n = 0; n < HEADER_SIZE; n++) begin
            exp_q.push_back(ref_desc_flit(a, n, 1'b0));
        end
        receive_packet(exp_q);
        queue_packet(MESSAGE_REQUEST, req_prod[a], req_cons[a], req_addr[a], pay);
        exp_q = {};
        for (int n = 0; n < HEADER_SIZE; n++) begin
            exp_q.push_back(ref_desc_flit(a, n, 1'b1));
        end
        exp_q.push_back(NEW_APP);
        exp_q.push_back(INJECTOR_ADDRESS);
        exp_q = {exp_q, desc_q};
        receive_packet(exp_q);
        pay = {APP_ALLOCATION_REQUEST, app_id[a]};
        for (int t = 0; t < app_tasks[a]; t++) begin
            pay.push_back(target[a][t]);
        end
        queue_packet(MESSAGE_DELIVERY, '0, '0, '0, pay);
        for (int t = 0; t < app_tasks[a]; t++) begin
            exp_q = {};
            src_q = {src_q, text_sz[a][t], data_sz[a][t], bss_sz[a][t], entry_sz[a][t]};
            for (int n = 0; n < HEADER_SIZE; n++) begin
                exp_q.push_back(ref_task_flit(a, t, n));
            end
            code = int'((text_sz[a][t] + data_sz[a][t]) >> 2);
            for (int i = 0; i < code; i++) begin
                exp_q.push_back(rand_bits(32));
                src_q.push_back(exp_q[exp_q.size() - 1]);
            end
            receive_packet(exp_q);
        end
        pay = {APP_MAPPING_COMPLETE};
        queue_packet(MESSAGE_DELIVERY, '0, '0, '0, pay);
        flush_input(4);
    endtask

    initial begin
        int    flits;
        flit_t pay [$];
        clk_i        = 1'b0;
        rst_ni       = 1'b0;
        src_rx_i     = 1'b0;
        src_data_i   = '0;
        noc_credit_i = 1'b0;
        noc_rx_i     = 1'b0;
        noc_data_i   = '0;
        lfsr         = 32'h1910_2be8;
        drain_mode   = 1'b0;
        cycle_cnt    = 0;
        app_tasks[0] = 3;
        app_tasks[1] = 5;
        flits        = 52 + 13;  // Oversized and unknown-service packets
        for (int a = 0; a < NUM_APPS; a++) begin
            app_id[a]   = rand_bits(8);
            req_addr[a] = rand_bits(16);
            req_prod[a] = rand_bits(16);
            req_cons[a] = rand_bits(16);
            flits = flits + 13 + (2 * app_tasks[a] + 16) + 13 + (app_tasks[a] + 15) + 14;
            flits = flits + 6 * app_tasks[a] + 1;
            for (int t = 0; t < app_tasks[a]; t++) begin
                text_sz[a][t]  = (rand_bits(2) + 32'd1) << 2;
                data_sz[a][t]  = rand_bits(2) << 2;
                bss_sz[a][t]   = rand_bits(8);
                entry_sz[a][t] = rand_bits(8);
                target[a][t]   = rand_bits(16);
                flits = flits + 13 + 2 * int'((text_sz[a][t] + data_sz[a][t]) >> 2);
            end
        end
        cycle_limit = 40 * flits + 500;
        repeat (10) @(negedge clk_i);
        rst_ni = 1'b1;
        #1;
        check_bit("noc_tx_o", noc_tx_o, 1'b0);
        check_bit("src_credit_o", src_credit_o, 1'b0);
        check_bit("noc_credit_o", noc_credit_o, 1'b1);
        run_app(0);
        pay = {};
        queue_packet(32'h0000_0077, '0, '0, '0, pay);  // Unknown service
        flush_input(4);
        for (int i = 0; i < 39; i++) begin
            pay.push_back(rand_bits(32));
        end
        drain_mode = 1'b1;
        queue_packet(MESSAGE_REQUEST, '0, '0, MAPPER_ADDRESS, pay);  // P of 50
        flush_input(4);
        drain_mode = 1'b0;
        run_app(1);
        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

//--- task_injector.f
+incdir+tb
rtl/noc_proto_pkg.sv
rtl/injector_pkg.sv
rtl/inject_ctrl.sv
rtl/packet_sender.sv
rtl/packet_receiver.sv
rtl/task_injector.sv
tb/task_injector_checker.sv
tb/tb_task_injector.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the task injector testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
    --top-module tb_task_injector \
    -f task_injector.f \
    -o sim_task_injector
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_task_injector
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished with status 0"
exit 0
